// File: hdl/bls_copro_pkg.sv
/*
  Shared widths, opcodes, point types and interrupt header constants
*/
package bls_copro_pkg;

  localparam int SLOT_DAT_BITS  = 64;
  localparam int PT_BITS        = 3;
  localparam int DATA_RAM_DEPTH = 256;
  localparam int INST_RAM_DEPTH = 64;
  // Address register to valid read data
  localparam int READ_CYCLE     = 2;
  localparam int TX_BITS        = 16;
  localparam int BEATS_PER_SLOT = 4;
  localparam int HDR_BEATS      = 2;
  localparam int IDX_FIFO_DEPTH = 4;
  localparam logic [7:0] INTR_MSG_CODE = 8'hA5;

  typedef logic [SLOT_DAT_BITS-1:0] slot_dat_t;
  // Point type on top, slot data below
  typedef logic [PT_BITS+SLOT_DAT_BITS-1:0] data_word_t;
  typedef logic [$clog2(DATA_RAM_DEPTH)-1:0] slot_addr_t;
  typedef logic [$clog2(INST_RAM_DEPTH)-1:0] inst_addr_t;
  // Opcode 39:32, field a 31:16, field b 15:0
  typedef logic [39:0] inst_word_t;
  typedef logic [TX_BITS-1:0] beat_t;
  typedef logic [15:0] intr_idx_t;
  typedef logic [PT_BITS+$bits(intr_idx_t)-1:0] idx_rec_t;
  typedef logic [2:0] slot_cnt_t;
  typedef logic [$clog2(BEATS_PER_SLOT+1)-1:0] beat_cnt_t;

  typedef enum logic [7:0] {
    NOOP_WAIT      = 8'd0,
    COPY_REG       = 8'd1,
    SEND_INTERRUPT = 8'd6
  } opcode_e;

  typedef enum logic [PT_BITS-1:0] {
    SCALAR = 3'd0,
    FP_AF  = 3'd1,
    FP_JB  = 3'd2,
    FP2_AF = 3'd3,
    FP2_JB = 3'd4
  } point_type_e;

  // Number of slots a point of this type occupies
  function automatic slot_cnt_t point_slot_count(input point_type_e pt);
    case (pt)
      FP_AF:   return 3'd2;
      FP_JB:   return 3'd3;
      FP2_AF:  return 3'd4;
      FP2_JB:  return 3'd6;
      default: return 3'd1;
    endcase
  endfunction

endpackage

// File: hdl/ram_port_if.sv
`timescale 1ns/1ps
/* One RAM port, driven by its owner and served by the RAM */
interface ram_port_if #(
  parameter int WIDTH     = 8,
  parameter int ADDR_BITS = 8
);

  logic                 en;
  logic                 we;
  logic [ADDR_BITS-1:0] addr;
  logic [WIDTH-1:0]     wdat;
  logic [WIDTH-1:0]     rdat;

  modport owner (output en, we, addr, wdat, input rdat);
  modport ram (input en, we, addr, wdat, output rdat);

endinterface

// File: hdl/stream_if.sv
`timescale 1ns/1ps
/* Valid/ready stream with data and end of packet */
interface stream_if #(
  parameter int WIDTH = 16
);

  logic             val;
  logic             rdy;
  logic [WIDTH-1:0] dat;
  logic             eop;

  // Source holds dat and eop while val is high and rdy is low
  modport source (output val, dat, eop, input rdy);
  modport sink (input val, dat, eop, output rdy);

endinterface

// File: hdl/slot_ram.sv
`timescale 1ns/1ps
/*
  True dual-port RAM with a fixed read pipeline per port
  Used for both the instruction and the slot memories
*/
module slot_ram #(
  parameter int WIDTH = 67,
  parameter int DEPTH = 256
) (
  input logic     i_clk,
  ram_port_if.ram port_a,
  ram_port_if.ram port_b
);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [WIDTH-1:0] pipe_a [bls_copro_pkg::READ_CYCLE];
  logic [WIDTH-1:0] pipe_b [bls_copro_pkg::READ_CYCLE];

  assign port_a.rdat = pipe_a[bls_copro_pkg::READ_CYCLE-1];
  assign port_b.rdat = pipe_b[bls_copro_pkg::READ_CYCLE-1];

  // Reads see the old word on a same-cycle write
  always_ff @(posedge i_clk) begin
    if (port_a.en && port_a.we) begin
      mem[port_a.addr] <= port_a.wdat;
    end
    // Port b wins a same-address write collision
    if (port_b.en && port_b.we) begin
      mem[port_b.addr] <= port_b.wdat;
    end
    if (port_a.en) begin
      pipe_a[0] <= mem[port_a.addr];
    end
    if (port_b.en) begin
      pipe_b[0] <= mem[port_b.addr];
    end
    for (int i = 1; i < bls_copro_pkg::READ_CYCLE; i++) begin
      pipe_a[i] <= pipe_a[i-1];
      pipe_b[i] <= pipe_b[i-1];
    end
  end

endmodule

// File: hdl/inst_sequencer.sv
`timescale 1ns/1ps
/*
  Instruction sequencer, runs NOOP_WAIT, COPY_REG and SEND_INTERRUPT
  from the instruction RAM against the slot RAM
*/
module inst_sequencer (
  input  logic                      i_clk,
  input  logic                      i_rst,
  ram_port_if.owner                 inst_sys,
  ram_port_if.owner                 data_sys,
  output logic                      o_idx_val,
  output bls_copro_pkg::idx_rec_t   o_idx_rec,
  input  logic                      i_idx_rdy,
  stream_if.source                  slot_s,
  output bls_copro_pkg::inst_addr_t o_inst_ptr
);

  bls_copro_pkg::opcode_e             inst_state;
  bls_copro_pkg::opcode_e             fetched_op;
  logic [1:0]                         step;
  logic [bls_copro_pkg::READ_CYCLE:0] inst_rd;
  logic [bls_copro_pkg::READ_CYCLE:0] data_rd;
  bls_copro_pkg::inst_word_t          curr_inst;
  bls_copro_pkg::data_word_t          curr_data;
  bls_copro_pkg::point_type_e         curr_pt;
  bls_copro_pkg::slot_dat_t           curr_dat;
  bls_copro_pkg::slot_addr_t          inst_a;
  bls_copro_pkg::intr_idx_t           inst_b;
  bls_copro_pkg::slot_cnt_t           slots_left;
  bls_copro_pkg::slot_cnt_t           first_cnt;

  assign curr_inst  = inst_sys.rdat;
  assign curr_data  = data_sys.rdat;
  assign curr_pt    = bls_copro_pkg::point_type_e'(curr_data[66:64]);
  assign curr_dat   = curr_data[63:0];
  assign first_cnt  = bls_copro_pkg::point_slot_count(curr_pt);
  assign o_inst_ptr = inst_sys.addr;

  // Instruction side only reads
  assign inst_sys.en   = 1'b1;
  assign inst_sys.we   = 1'b0;
  assign inst_sys.wdat = '0;
  assign data_sys.en   = 1'b1;

  // Unknown opcodes behave as NOOP_WAIT
  always_comb begin
    fetched_op = bls_copro_pkg::opcode_e'(curr_inst[39:32]);
    if (fetched_op != bls_copro_pkg::COPY_REG &&
        fetched_op != bls_copro_pkg::SEND_INTERRUPT) begin
      fetched_op = bls_copro_pkg::NOOP_WAIT;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      inst_state    <= bls_copro_pkg::NOOP_WAIT;
      step          <= '0;
      inst_rd       <= '0;
      data_rd       <= '0;
      inst_sys.addr <= '0;
      data_sys.addr <= '0;
      data_sys.we   <= 1'b0;
      o_idx_val     <= 1'b0;
      slot_s.val    <= 1'b0;
      slots_left    <= '0;
    end else begin
      inst_rd     <= inst_rd << 1;
      data_rd     <= data_rd << 1;
      data_sys.we <= 1'b0;
      if (o_idx_val && i_idx_rdy) begin
        o_idx_val <= 1'b0;
      end
      if (slot_s.val && slot_s.rdy) begin
        slot_s.val <= 1'b0;
      end

      case (inst_state)
        bls_copro_pkg::NOOP_WAIT: begin
          // Poll the current instruction until it changes
          if (inst_rd[bls_copro_pkg::READ_CYCLE]) begin
            inst_state <= fetched_op;
            inst_a     <= curr_inst[23:16];
            inst_b     <= curr_inst[15:0];
            step       <= '0;
            if (fetched_op == bls_copro_pkg::NOOP_WAIT) begin
              inst_rd[0] <= 1'b1;
            end
          end else if (inst_rd == '0) begin
            inst_rd[0] <= 1'b1;
          end
        end
        bls_copro_pkg::COPY_REG: begin
          if (step == 2'd0) begin
            data_sys.addr <= inst_a;
            data_rd[0]    <= 1'b1;
            step          <= 2'd1;
          end else if (data_rd[bls_copro_pkg::READ_CYCLE]) begin
            data_sys.addr <= bls_copro_pkg::slot_addr_t'(inst_b);
            data_sys.wdat <= curr_data;
            data_sys.we   <= 1'b1;
            inst_sys.addr <= inst_sys.addr + 1'b1;
            inst_rd[0]    <= 1'b1;
            inst_state    <= bls_copro_pkg::NOOP_WAIT;
          end
        end
        bls_copro_pkg::SEND_INTERRUPT: begin
          case (step)
            2'd0: begin
              // Index FIFO must have room before any slot is read
              if (i_idx_rdy) begin
                data_sys.addr <= inst_a;
                data_rd[0]    <= 1'b1;
                step          <= 2'd1;
              end
            end
            2'd1: begin
              // First slot sets the point type and length
              if (data_rd[bls_copro_pkg::READ_CYCLE]) begin
                o_idx_val  <= 1'b1;
                o_idx_rec  <= {curr_pt, inst_b};
                slots_left <= first_cnt;
                slot_s.val <= 1'b1;
                slot_s.dat <= curr_dat;
                slot_s.eop <= (first_cnt == 3'd1);
                step       <= 2'd2;
              end
            end
            2'd2: begin
              if (slot_s.val && slot_s.rdy) begin
                if (slots_left == 3'd1) begin
                  inst_sys.addr <= inst_sys.addr + 1'b1;
                  inst_rd[0]    <= 1'b1;
                  inst_state    <= bls_copro_pkg::NOOP_WAIT;
                end else begin
                  slots_left    <= slots_left - 1'b1;
                  data_sys.addr <= data_sys.addr + 1'b1;
                  data_rd[0]    <= 1'b1;
                  step          <= 2'd3;
                end
              end
            end
            default: begin
              if (data_rd[bls_copro_pkg::READ_CYCLE]) begin
                slot_s.val <= 1'b1;
                slot_s.dat <= curr_dat;
                slot_s.eop <= (slots_left == 3'd1);
                step       <= 2'd2;
              end
            end
          endcase
        end
        default: begin
          inst_state <= bls_copro_pkg::NOOP_WAIT;
        end
      endcase
    end
  end

endmodule

// File: hdl/intr_index_fifo.sv
`timescale 1ns/1ps
/* Small first-word FIFO of pending interrupt index records */
module intr_index_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_val,
  input  bls_copro_pkg::idx_rec_t i_rec,
  output logic                    o_rdy,
  output logic                    o_val,
  output bls_copro_pkg::idx_rec_t o_rec,
  input  logic                    i_rdy
);

  bls_copro_pkg::idx_rec_t      mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   count;
  logic                         push;
  logic                         pop;

  assign o_rdy = (count != DEPTH);
  assign o_val = (count != '0);
  assign o_rec = mem[rd_ptr];
  assign push  = i_val && o_rdy;
  assign pop   = o_val && i_rdy;

  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_rec;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == DEPTH-1) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH-1) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: hdl/slot_width_converter.sv
`timescale 1ns/1ps
/* Splits each 64-bit slot into 16-bit beats, low bits first */
module slot_width_converter (
  input  logic     i_clk,
  input  logic     i_rst,
  stream_if.sink   slot_s,
  stream_if.source beat_s
);

  bls_copro_pkg::slot_dat_t hold;
  bls_copro_pkg::beat_cnt_t beats_left;
  logic                     hold_eop;

  // New slot only once the last beat has left
  assign slot_s.rdy = (beats_left == '0);
  assign beat_s.val = (beats_left != '0);
  assign beat_s.dat = hold[bls_copro_pkg::TX_BITS-1:0];
  assign beat_s.eop = hold_eop && (beats_left == bls_copro_pkg::beat_cnt_t'(1));

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      beats_left <= '0;
    end else if (slot_s.val && slot_s.rdy) begin
      beats_left <= bls_copro_pkg::beat_cnt_t'(bls_copro_pkg::BEATS_PER_SLOT);
    end else if (beat_s.val && beat_s.rdy) begin
      beats_left <= beats_left - 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (slot_s.val && slot_s.rdy) begin
      hold     <= slot_s.dat;
      hold_eop <= slot_s.eop;
    end else if (beat_s.val && beat_s.rdy) begin
      hold <= hold >> bls_copro_pkg::TX_BITS;
    end
  end

endmodule

// File: hdl/intr_tx_framer.sv
`timescale 1ns/1ps
/*
  Interrupt framer, sends the header beats from an index record
  and then forwards the slot data beats on the transmit port
*/
module intr_tx_framer (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_idx_val,
  input  bls_copro_pkg::idx_rec_t i_idx_rec,
  output logic                    o_idx_rdy,
  stream_if.sink                  beat_s,
  input  logic                    i_tx_rdy,
  output logic                    o_tx_val,
  output logic                    o_tx_sop,
  output logic                    o_tx_eop,
  output bls_copro_pkg::beat_t    o_tx_dat
);

  typedef enum logic [1:0] {WAIT_IDX, SEND_HDR, SEND_DATA} frame_state_e;

  frame_state_e            state;
  bls_copro_pkg::idx_rec_t rec;
  logic [1:0]              hdr_idx;
  logic                    tx_free;
  bls_copro_pkg::beat_t    hdr_code;

  // Output register can load when empty or being taken
  assign tx_free   = !o_tx_val || i_tx_rdy;
  assign o_idx_rdy = (state == WAIT_IDX);
  assign beat_s.rdy = (state == SEND_DATA) && tx_free && !(o_tx_val && o_tx_eop);

  // Message code in the upper byte, point type in the low bits
  assign hdr_code = {bls_copro_pkg::INTR_MSG_CODE,
                     {(bls_copro_pkg::TX_BITS-8-bls_copro_pkg::PT_BITS){1'b0}},
                     rec[18:16]};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= WAIT_IDX;
      hdr_idx  <= '0;
      o_tx_val <= 1'b0;
      o_tx_sop <= 1'b0;
      o_tx_eop <= 1'b0;
    end else begin
      case (state)
        WAIT_IDX: begin
          if (i_idx_val) begin
            rec     <= i_idx_rec;
            hdr_idx <= '0;
            state   <= SEND_HDR;
          end
        end
        SEND_HDR: begin
          if (tx_free) begin
            o_tx_val <= 1'b1;
            o_tx_sop <= (hdr_idx == 2'd0);
            o_tx_eop <= 1'b0;
            o_tx_dat <= (hdr_idx == 2'd0) ? rec[15:0] : hdr_code;
            hdr_idx  <= hdr_idx + 1'b1;
            if (hdr_idx == 2'(bls_copro_pkg::HDR_BEATS - 1)) begin
              state <= SEND_DATA;
            end
          end
        end
        default: begin
          if (tx_free) begin
            // Packet ends once its eop beat is taken
            if (o_tx_val && o_tx_eop) begin
              o_tx_val <= 1'b0;
              o_tx_eop <= 1'b0;
              state    <= WAIT_IDX;
            end else begin
              o_tx_val <= beat_s.val;
              o_tx_sop <= 1'b0;
              o_tx_eop <= beat_s.val && beat_s.eop;
              o_tx_dat <= beat_s.dat;
            end
          end
        end
      endcase
    end
  end

endmodule

// File: hdl/bls_copro_top.sv
`timescale 1ns/1ps
/*
  Coprocessor sequencer top level with user RAM ports
  and the interrupt transmit port
*/
module bls_copro_top (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_usr_inst_we,
  input  bls_copro_pkg::inst_addr_t i_usr_inst_addr,
  input  bls_copro_pkg::inst_word_t i_usr_inst_dat,
  input  logic                      i_usr_data_we,
  input  bls_copro_pkg::slot_addr_t i_usr_data_addr,
  input  bls_copro_pkg::data_word_t i_usr_data_dat,
  output bls_copro_pkg::data_word_t o_usr_data_q,
  output bls_copro_pkg::inst_addr_t o_inst_ptr,
  input  logic                      i_tx_rdy,
  output logic                      o_tx_val,
  output logic                      o_tx_sop,
  output logic                      o_tx_eop,
  output bls_copro_pkg::beat_t      o_tx_dat
);

  ram_port_if #(
    .WIDTH     ($bits(bls_copro_pkg::inst_word_t)),
    .ADDR_BITS ($bits(bls_copro_pkg::inst_addr_t))
  ) inst_usr (), inst_sys ();

  ram_port_if #(
    .WIDTH     ($bits(bls_copro_pkg::data_word_t)),
    .ADDR_BITS ($bits(bls_copro_pkg::slot_addr_t))
  ) data_usr (), data_sys ();

  stream_if #(.WIDTH(bls_copro_pkg::SLOT_DAT_BITS)) slot_s ();
  stream_if #(.WIDTH(bls_copro_pkg::TX_BITS))       beat_s ();

  logic                    idx_val;
  logic                    idx_rdy;
  bls_copro_pkg::idx_rec_t idx_rec;
  logic                    fifo_val;
  logic                    fifo_rdy;
  bls_copro_pkg::idx_rec_t fifo_rec;

  // User ports are always enabled
  assign inst_usr.en   = 1'b1;
  assign inst_usr.we   = i_usr_inst_we;
  assign inst_usr.addr = i_usr_inst_addr;
  assign inst_usr.wdat = i_usr_inst_dat;
  assign data_usr.en   = 1'b1;
  assign data_usr.we   = i_usr_data_we;
  assign data_usr.addr = i_usr_data_addr;
  assign data_usr.wdat = i_usr_data_dat;
  assign o_usr_data_q  = data_usr.rdat;

  slot_ram #(
    .WIDTH ($bits(bls_copro_pkg::inst_word_t)),
    .DEPTH (bls_copro_pkg::INST_RAM_DEPTH)
  ) u_inst_ram (.i_clk(i_clk), .port_a(inst_usr), .port_b(inst_sys));

  slot_ram #(
    .WIDTH ($bits(bls_copro_pkg::data_word_t)),
    .DEPTH (bls_copro_pkg::DATA_RAM_DEPTH)
  ) u_data_ram (.i_clk(i_clk), .port_a(data_usr), .port_b(data_sys));

  inst_sequencer u_seq (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .inst_sys   (inst_sys),
    .data_sys   (data_sys),
    .o_idx_val  (idx_val),
    .o_idx_rec  (idx_rec),
    .i_idx_rdy  (idx_rdy),
    .slot_s     (slot_s),
    .o_inst_ptr (o_inst_ptr)
  );

  intr_index_fifo #(.DEPTH(bls_copro_pkg::IDX_FIFO_DEPTH)) u_idx_fifo (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_val (idx_val),
    .i_rec (idx_rec),
    .o_rdy (idx_rdy),
    .o_val (fifo_val),
    .o_rec (fifo_rec),
    .i_rdy (fifo_rdy)
  );

  slot_width_converter u_conv (
    .i_clk  (i_clk),
    .i_rst  (i_rst),
    .slot_s (slot_s),
    .beat_s (beat_s)
  );

  intr_tx_framer u_framer (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_idx_val (fifo_val),
    .i_idx_rec (fifo_rec),
    .o_idx_rdy (fifo_rdy),
    .beat_s    (beat_s),
    .i_tx_rdy  (i_tx_rdy),
    .o_tx_val  (o_tx_val),
    .o_tx_sop  (o_tx_sop),
    .o_tx_eop  (o_tx_eop),
    .o_tx_dat  (o_tx_dat)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps
/* Testbench clock source, 100 ns period */
module tb_clk_gen #(
  parameter int HALF_PERIOD_NS = 50
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
  end

  always #HALF_PERIOD_NS o_clk = ~o_clk;

endmodule

// File: verif/bls_copro_props.sv
`timescale 1ns/1ps
/* Concurrent checks on the transmit port and reset state, bound into the top */
module bls_copro_props (
  input logic                      i_clk,
  input logic                      i_rst,
  input logic                      i_tx_rdy,
  input logic                      o_tx_val,
  input logic                      o_tx_sop,
  input logic                      o_tx_eop,
  input bls_copro_pkg::beat_t      o_tx_dat,
  input bls_copro_pkg::inst_addr_t o_inst_ptr
);

  logic in_pkt;
  // Count of failed assertions
  int   fail_count = 0;

  // High between an accepted sop beat and its eop beat
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      in_pkt <= 1'b0;
    end else if (o_tx_val && i_tx_rdy) begin
      if (o_tx_eop) begin
        in_pkt <= 1'b0;
      end else if (o_tx_sop) begin
        in_pkt <= 1'b1;
      end
    end
  end

  tx_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && !i_tx_rdy |=> o_tx_val && $stable(o_tx_dat) &&
                              $stable(o_tx_sop) && $stable(o_tx_eop))
    else begin
      $error("transmit beat changed while stalled");
      fail_count++;
    end

  no_nested_sop: assert property (@(posedge i_clk) disable iff (i_rst)
    o_tx_val && in_pkt |-> !o_tx_sop)
    else begin
      $error("sop seen inside an open packet");
      fail_count++;
    end

  tx_idle_after_rst: assert property (@(posedge i_clk) i_rst |=> !o_tx_val)
    else begin
      $error("o_tx_val high right after reset");
      fail_count++;
    end

  ptr_zero_after_rst: assert property (@(posedge i_clk) i_rst |=> o_inst_ptr == '0)
    else begin
      $error("instruction pointer not zero after reset");
      fail_count++;
    end

endmodule

bind bls_copro_top bls_copro_props u_props (
  .i_clk      (i_clk),
  .i_rst      (i_rst),
  .i_tx_rdy   (i_tx_rdy),
  .o_tx_val   (o_tx_val),
  .o_tx_sop   (o_tx_sop),
  .o_tx_eop   (o_tx_eop),
  .o_tx_dat   (o_tx_dat),
  .o_inst_ptr (o_inst_ptr)
);

// File: verif/tb_bls_copro.sv
`timescale 1ns/1ps
/*
  Directed testbench for the coprocessor sequencer with a slot RAM model
  and an expected packet builder for the interrupt transmit port
*/
module tb_bls_copro;

  localparam int RST_CYCLES = 2;
  localparam logic [31:0] LFSR_SEED = 32'h01b2_3788;

  logic                      i_clk;
  logic                      i_rst;
  logic                      i_usr_inst_we;
  bls_copro_pkg::inst_addr_t i_usr_inst_addr;
  bls_copro_pkg::inst_word_t i_usr_inst_dat;
  logic                      i_usr_data_we;
  bls_copro_pkg::slot_addr_t i_usr_data_addr;
  bls_copro_pkg::data_word_t i_usr_data_dat;
  bls_copro_pkg::data_word_t o_usr_data_q;
  bls_copro_pkg::inst_addr_t o_inst_ptr;
  logic                      i_tx_rdy;
  logic                      o_tx_val;
  logic                      o_tx_sop;
  logic                      o_tx_eop;
  bls_copro_pkg::beat_t      o_tx_dat;

  bls_copro_pkg::data_word_t slot_model [bls_copro_pkg::DATA_RAM_DEPTH];
  bls_copro_pkg::beat_t      exp_dat [$];
  logic                      exp_sop [$];
  logic                      exp_eop [$];
  bls_copro_pkg::inst_addr_t prog_ptr;
  logic [31:0]               lfsr_state;
  int                        errors;
  int                        tests_run;
  int                        tests_failed;
  int                        assert_fails;
  logic                      timed_out;

  tb_clk_gen u_clk (.o_clk(i_clk));

  bls_copro_top DUT (.*);

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[62:0], lfsr_state[0]};
    end
  endtask

  // Slots a point of each type occupies
  function automatic int slots_for_type(input logic [2:0] pt);
    case (pt)
      3'd1:    return 2;
      3'd2:    return 3;
      3'd3:    return 4;
      3'd4:    return 6;
      default: return 1;
    endcase
  endfunction

  function automatic bls_copro_pkg::inst_word_t make_inst(input logic [7:0] op,
                                                         input logic [15:0] a,
                                                         input logic [15:0] b);
    return {op, a, b};
  endfunction

  task automatic check_beat(input string name, input bls_copro_pkg::beat_t got,
                            input bls_copro_pkg::beat_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input bls_copro_pkg::data_word_t got,
                            input bls_copro_pkg::data_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_ptr(input string name, input bls_copro_pkg::inst_addr_t got,
                           input bls_copro_pkg::inst_addr_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // All driving tasks start and end just after a falling edge
  task automatic write_slot(input bls_copro_pkg::slot_addr_t addr,
                            input bls_copro_pkg::data_word_t word);
    i_usr_data_we   = 1'b1;
    i_usr_data_addr = addr;
    i_usr_data_dat  = word;
    slot_model[addr] = word;
    @(negedge i_clk);
    i_usr_data_we = 1'b0;
  endtask

  task automatic write_inst(input bls_copro_pkg::inst_addr_t addr,
                            input bls_copro_pkg::inst_word_t word);
    i_usr_inst_we   = 1'b1;
    i_usr_inst_addr = addr;
    i_usr_inst_dat  = word;
    @(negedge i_clk);
    i_usr_inst_we = 1'b0;
  endtask

  // One extra cycle lets a pending sequencer write land first
  task automatic read_slot(input bls_copro_pkg::slot_addr_t addr,
                           output bls_copro_pkg::data_word_t word);
    i_usr_data_addr = addr;
    repeat (bls_copro_pkg::READ_CYCLE + 1) @(negedge i_clk);
    word = o_usr_data_q;
  endtask

  task automatic random_word(input logic [2:0] pt, output bls_copro_pkg::data_word_t w);
    logic [63:0] bits;
    take_bits(64, bits);
    w = {pt, bits};
  endtask

  task automatic wait_ptr(input bls_copro_pkg::inst_addr_t exp, input int limit);
    int cyc;
    cyc = 0;
    while (o_inst_ptr !== exp && cyc < limit) begin
      @(negedge i_clk);
      cyc++;
    end
    if (o_inst_ptr !== exp) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: instruction pointer never reached %0d", exp);
    end
  endtask

  // Header beats, then each slot low bits first, eop on the very last beat
  task automatic expect_packet(input bls_copro_pkg::slot_addr_t a, input logic [15:0] b);
    bls_copro_pkg::data_word_t w;
    logic [2:0]                pt;
    int                        cnt;
    pt  = slot_model[a][66:64];
    cnt = slots_for_type(pt);
    exp_dat.push_back(b);
    exp_sop.push_back(1'b1);
    exp_eop.push_back(1'b0);
    exp_dat.push_back({bls_copro_pkg::INTR_MSG_CODE, 5'd0, pt});
    exp_sop.push_back(1'b0);
    exp_eop.push_back(1'b0);
    for (int s = 0; s < cnt; s++) begin
      w = slot_model[8'(a + s)];
      for (int j = 0; j < bls_copro_pkg::BEATS_PER_SLOT; j++) begin
        exp_dat.push_back(w[j*bls_copro_pkg::TX_BITS +: bls_copro_pkg::TX_BITS]);
        exp_sop.push_back(1'b0);
        exp_eop.push_back(s == cnt - 1 && j == bls_copro_pkg::BEATS_PER_SLOT - 1);
      end
    end
  endtask

  task automatic collect_beats(input logic rand_rdy, input int limit);
    int                   n;
    int                   k;
    int                   cyc;
    logic                 pend;
    logic [63:0]          bits;
    bls_copro_pkg::beat_t pend_dat;
    logic                 pend_sop;
    logic                 pend_eop;
    n    = exp_dat.size();
    k    = 0;
    cyc  = 0;
    pend = 1'b0;
    while (k < n && cyc < limit) begin
      // A stalled beat must still be offered unchanged
      if (pend) begin
        check_flag("o_tx_val", o_tx_val, 1'b1);
        check_beat("o_tx_dat", o_tx_dat, pend_dat);
        check_flag("o_tx_sop", o_tx_sop, pend_sop);
        check_flag("o_tx_eop", o_tx_eop, pend_eop);
      end
      if (rand_rdy) begin
        take_bits(1, bits);
        i_tx_rdy = bits[0];
      end else begin
        i_tx_rdy = 1'b1;
      end
      pend     = o_tx_val && !i_tx_rdy;
      pend_dat = o_tx_dat;
      pend_sop = o_tx_sop;
      pend_eop = o_tx_eop;
      if (o_tx_val && i_tx_rdy) begin
        check_beat("o_tx_dat", o_tx_dat, exp_dat[k]);
        check_flag("o_tx_sop", o_tx_sop, exp_sop[k]);
        check_flag("o_tx_eop", o_tx_eop, exp_eop[k]);
        k++;
      end
      @(negedge i_clk);
      cyc++;
    end
    i_tx_rdy = 1'b0;
    if (k < n) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: only %0d of %0d transmit beats arrived", k, n);
    end else begin
      check_flag("o_tx_val", o_tx_val, 1'b0);
    end
    exp_dat.delete();
    exp_sop.delete();
    exp_eop.delete();
  endtask

  task automatic end_test(input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    end
  endtask

  // NOOP words carry the address in both fields
  task automatic reset_and_fill();
    i_rst = 1'b1;
    for (int i = 0; i < bls_copro_pkg::INST_RAM_DEPTH; i++) begin
      @(negedge i_clk);
      if (i == RST_CYCLES - 1) begin
        i_rst = 1'b0;
      end
      i_usr_inst_we   = 1'b1;
      i_usr_inst_addr = bls_copro_pkg::inst_addr_t'(i);
      i_usr_inst_dat  = make_inst(8'h00, 16'(i), 16'(i));
    end
    @(negedge i_clk);
    i_usr_inst_we = 1'b0;
  endtask

  task automatic test_idle();
    int err0;
    err0 = errors;
    check_flag("o_tx_val", o_tx_val, 1'b0);
    check_ptr("o_inst_ptr", o_inst_ptr, '0);
    for (int i = 0; i < 50; i++) begin
      @(negedge i_clk);
      check_ptr("o_inst_ptr", o_inst_ptr, '0);
    end
    end_test("idle after reset", err0);
  endtask

  task automatic test_copy();
    int                        err0;
    bls_copro_pkg::data_word_t w;
    err0 = errors;
    random_word(bls_copro_pkg::FP_AF, w);
    write_slot(8'h10, w);
    random_word(bls_copro_pkg::SCALAR, w);
    write_slot(8'h20, w);
    write_inst(prog_ptr, make_inst(bls_copro_pkg::COPY_REG, 16'h0010, 16'h0020));
    slot_model[8'h20] = slot_model[8'h10];
    prog_ptr++;
    wait_ptr(prog_ptr, 200);
    read_slot(8'h20, w);
    check_word("o_usr_data_q", w, slot_model[8'h20]);
    read_slot(8'h10, w);
    check_word("o_usr_data_q", w, slot_model[8'h10]);
    end_test("copy slot", err0);
  endtask

  task automatic test_send_scalar();
    int                        err0;
    bls_copro_pkg::data_word_t w;
    err0 = errors;
    random_word(bls_copro_pkg::SCALAR, w);
    write_slot(8'h30, w);
    expect_packet(8'h30, 16'h0c3a);
    write_inst(prog_ptr, make_inst(bls_copro_pkg::SEND_INTERRUPT, 16'h0030, 16'h0c3a));
    prog_ptr++;
    collect_beats(1'b0, 500);
    wait_ptr(prog_ptr, 200);
    end_test("send scalar", err0);
  endtask

  task automatic test_send_point();
    int                        err0;
    bls_copro_pkg::data_word_t w;
    err0 = errors;
    for (int s = 0; s < 6; s++) begin
      random_word(bls_copro_pkg::FP2_JB, w);
      write_slot(8'(8'h40 + s), w);
    end
    expect_packet(8'h40, 16'hbeef);
    write_inst(prog_ptr, make_inst(bls_copro_pkg::SEND_INTERRUPT, 16'h0040, 16'hbeef));
    prog_ptr++;
    collect_beats(1'b1, 2000);
    wait_ptr(prog_ptr, 200);
    end_test("send fp2 point, random ready", err0);
  endtask

  // Later words first, the word at the pointer last so the run starts whole
  task automatic test_program();
    int                        err0;
    bls_copro_pkg::data_word_t w;
    err0 = errors;
    random_word(bls_copro_pkg::SCALAR, w);
    write_slot(8'h50, w);
    random_word(bls_copro_pkg::FP_AF, w);
    write_slot(8'h60, w);
    for (int s = 0; s < 3; s++) begin
      random_word(bls_copro_pkg::FP_JB, w);
      write_slot(8'(8'h70 + s), w);
    end
    write_inst(prog_ptr + 1, make_inst(bls_copro_pkg::SEND_INTERRUPT, 16'h0070, 16'h0102));
    write_inst(prog_ptr + 2, make_inst(bls_copro_pkg::SEND_INTERRUPT, 16'h0060, 16'h0203));
    write_inst(prog_ptr + 3, make_inst(bls_copro_pkg::NOOP_WAIT, 16'h0000, 16'h0000));
    slot_model[8'h60] = slot_model[8'h50];
    expect_packet(8'h70, 16'h0102);
    expect_packet(8'h60, 16'h0203);
    write_inst(prog_ptr, make_inst(bls_copro_pkg::COPY_REG, 16'h0050, 16'h0060));
    prog_ptr = prog_ptr + 3;
    collect_beats(1'b1, 3000);
    wait_ptr(prog_ptr, 200);
    repeat (10) @(negedge i_clk);
    check_ptr("o_inst_ptr", o_inst_ptr, prog_ptr);
    end_test("copy then two sends", err0);
  endtask

  initial begin
    i_rst           = 1'b1;
    i_usr_inst_we   = 1'b0;
    i_usr_inst_addr = '0;
    i_usr_inst_dat  = '0;
    i_usr_data_we   = 1'b0;
    i_usr_data_addr = '0;
    i_usr_data_dat  = '0;
    i_tx_rdy        = 1'b0;
    lfsr_state      = LFSR_SEED;
    prog_ptr        = '0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    timed_out       = 1'b0;
    reset_and_fill();
    test_idle();
    if (!timed_out) test_copy();
    if (!timed_out) test_send_scalar();
    if (!timed_out) test_send_point();
    if (!timed_out) test_program();
    assert_fails = DUT.u_props.fail_count;
    $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// File: bls_copro_top.f
hdl/bls_copro_pkg.sv
hdl/ram_port_if.sv
hdl/stream_if.sv
hdl/slot_ram.sv
hdl/inst_sequencer.sv
hdl/intr_index_fifo.sv
hdl/slot_width_converter.sv
hdl/intr_tx_framer.sv
hdl/bls_copro_top.sv
verif/tb_clk_gen.sv
verif/bls_copro_props.sv
verif/tb_bls_copro.sv
